//--- Bender.yml
package:
  name: datapath_core

sources:
  - hdl/dsp_pkg.sv
  - hdl/dsp_cfg_regs.sv
  - hdl/ffe_slicer.sv
  - hdl/channel_filter.sv
  - hdl/sliding_detector.sv
  - hdl/datapath_core.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/datapath_core_tb.sv

//--- build.f
+incdir+tests
hdl/dsp_pkg.sv
hdl/dsp_cfg_regs.sv
hdl/ffe_slicer.sv
hdl/channel_filter.sv
hdl/sliding_detector.sv
hdl/datapath_core.sv
tests/datapath_core_tb.sv

//--- hdl/channel_filter.sv
`timescale 1ns/1ps
`default_nettype none

module channel_filter (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic [dsp_pkg::lanes-1:0]             bits_i,
    input  logic signed [dsp_pkg::chan_w-1:0]     taps_i [dsp_pkg::chan_taps-1:0],
    input  logic [dsp_pkg::shift_w-1:0]           shift_i,
    output logic signed [dsp_pkg::est_code_w-1:0] est_codes_o [dsp_pkg::lanes-1:0]
);
    import dsp_pkg::*;

    logic [lanes-1:0]             prev_bits;
    logic [chan_span-1:0]         span;
    logic signed [est_code_w-1:0] acc [lanes-1:0];
    logic signed [est_code_w-1:0] est [lanes-1:0];

    // Oldest bit in the LSB
    assign span = {bits_i, prev_bits[lanes-1 -: chan_taps-1]};

    always_comb begin
        for (int s = 0; s < lanes; s++) begin
            acc[s] = '0;
            for (int k = 0; k < chan_taps; k++) begin
                // Bit 1 is +1, bit 0 is -1
                if (span[s + chan_taps - 1 - k]) begin
                    acc[s] = acc[s] + taps_i[k];
                end else begin
                    acc[s] = acc[s] - taps_i[k];
                end
            end
            est[s] = acc[s] >>> shift_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_bits <= '0;
            for (int s = 0; s < lanes; s++) begin
                est_codes_o[s] <= '0;
            end
        end else begin
            prev_bits <= bits_i;
            for (int s = 0; s < lanes; s++) begin
                est_codes_o[s] <= est[s];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/datapath_core.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_core (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic signed [dsp_pkg::code_w-1:0]  adc_codes_i [dsp_pkg::lanes-1:0],
    input  logic                               cfg_we_i,
    input  logic [dsp_pkg::cfg_addr_w-1:0]     cfg_addr_i,
    input  logic [dsp_pkg::cfg_data_w-1:0]     cfg_data_i,
    output logic [dsp_pkg::lanes-1:0]          bits_o,
    output logic [dsp_pkg::err_pos_w-1:0]      err_pos_o [dsp_pkg::lanes-1:0]
);
    import dsp_pkg::*;

    logic signed [weight_w-1:0]   ffe_weights [ffe_taps-1:0];
    logic signed [chan_w-1:0]     chan_taps_q [chan_taps-1:0];
    logic signed [thresh_w-1:0]   thresh;
    logic [shift_w-1:0]           ffe_shift;
    logic [shift_w-1:0]           chan_shift;

    logic [lanes-1:0]             sliced_bits;
    logic signed [est_code_w-1:0] est_codes [lanes-1:0];
    logic signed [code_w-1:0]     adc_dly [code_dly-1:0][lanes-1:0];
    logic signed [err_w-1:0]      errors [lanes-1:0];
    logic [lanes-1:0]             bit_dly [bits_dly-1:0];

    dsp_cfg_regs cfg_regs_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_data_i   (cfg_data_i),
        .ffe_weights_o(ffe_weights),
        .chan_taps_o  (chan_taps_q),
        .thresh_o     (thresh),
        .ffe_shift_o  (ffe_shift),
        .chan_shift_o (chan_shift)
    );

    ffe_slicer ffe_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .codes_i  (adc_codes_i),
        .weights_i(ffe_weights),
        .shift_i  (ffe_shift),
        .thresh_i (thresh),
        .bits_o   (sliced_bits)
    );

    channel_filter chan_filt_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .bits_i     (sliced_bits),
        .taps_i     (chan_taps_q),
        .shift_i    (chan_shift),
        .est_codes_o(est_codes)
    );

    // Codes wait two cycles for the rebuilt estimate, bits wait for the verdicts
    always_ff @(posedge clk) begin
        if (rst_i) begin
            adc_dly <= '{default: '0};
            errors <= '{default: '0};
            bit_dly <= '{default: '0};
        end else begin
            adc_dly[0] <= adc_codes_i;
            for (int d = 1; d < code_dly; d++) begin
                adc_dly[d] <= adc_dly[d-1];
            end
            for (int s = 0; s < lanes; s++) begin
                errors[s] <= est_codes[s] - adc_dly[code_dly-1][s];
            end
            bit_dly[0] <= sliced_bits;
            for (int d = 1; d < bits_dly; d++) begin
                bit_dly[d] <= bit_dly[d-1];
            end
        end
    end

    // Only taps 0 and 1 reach the two-sample window
    sliding_detector sld_dtct_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .errors_i (errors),
        .bits_i   (bit_dly[sd_bits_tap]),
        .taps_i   (chan_taps_q[sd_taps-1:0]),
        .err_pos_o(err_pos_o)
    );

    assign bits_o = bit_dly[bits_dly-1];

    cfg_addr_known_a: assert property (@(posedge clk) disable iff (rst_i)
        cfg_we_i |-> !$isunknown(cfg_addr_i));

endmodule

`default_nettype wire

//--- hdl/dsp_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_cfg_regs (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               cfg_we_i,
    input  logic [dsp_pkg::cfg_addr_w-1:0]     cfg_addr_i,
    input  logic [dsp_pkg::cfg_data_w-1:0]     cfg_data_i,
    output logic signed [dsp_pkg::weight_w-1:0] ffe_weights_o [dsp_pkg::ffe_taps-1:0],
    output logic signed [dsp_pkg::chan_w-1:0]   chan_taps_o [dsp_pkg::chan_taps-1:0],
    output logic signed [dsp_pkg::thresh_w-1:0] thresh_o,
    output logic [dsp_pkg::shift_w-1:0]         ffe_shift_o,
    output logic [dsp_pkg::shift_w-1:0]         chan_shift_o
);
    import dsp_pkg::*;

    cfg_word_u wr_word;

    assign wr_word = cfg_word_u'(cfg_data_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 0; k < ffe_taps; k++) begin
                ffe_weights_o[k] <= '0;
            end
            for (int k = 0; k < chan_taps; k++) begin
                chan_taps_o[k] <= '0;
            end
            // Pass-through equalizer and single-tap channel
            ffe_weights_o[0] <= 1;
            chan_taps_o[0] <= 1;
            thresh_o <= '0;
            ffe_shift_o <= '0;
            chan_shift_o <= '0;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == addr_ctrl) begin
                thresh_o <= wr_word.ctrl.thresh;
                ffe_shift_o <= wr_word.ctrl.ffe_shift;
                chan_shift_o <= wr_word.ctrl.chan_shift;
            end else begin
                // Tap k of both filters in one write
                ffe_weights_o[cfg_addr_i] <= wr_word.coef.weight;
                chan_taps_o[cfg_addr_i] <= wr_word.coef.tap;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    // Stream geometry
    localparam int lanes = 4;
    localparam int code_w = 8;

    // Equalizer
    localparam int ffe_taps = 3;
    localparam int weight_w = 8;
    localparam int ffe_acc_w = 18;
    localparam int thresh_w = 8;
    localparam int ffe_span = lanes + ffe_taps - 1;

    // Channel estimate
    localparam int chan_taps = 3;
    localparam int chan_w = 8;
    localparam int est_code_w = 10;
    localparam int chan_span = lanes + chan_taps - 1;

    localparam int shift_w = 4;

    // Error and detector
    localparam int err_w = 11;
    localparam int dev_w = err_w + 1;   // error plus a flip, keeps headroom for the sum
    localparam int cost_w = 24;
    localparam int sd_taps = 2;
    localparam int err_pos_w = 2;
    localparam logic [err_pos_w-1:0] err_pos_none = 2'd0;
    localparam logic [err_pos_w-1:0] err_pos_single = 2'd1;
    localparam logic [err_pos_w-1:0] err_pos_pair = 2'd2;

    // Delay lines in the core
    localparam int code_dly = 2;
    localparam int bits_dly = 4;
    localparam int sd_bits_tap = 1;

    // Configuration port
    localparam int cfg_addr_w = 2;
    localparam int cfg_data_w = 16;
    localparam logic [cfg_addr_w-1:0] addr_ctrl = 2'd3;

    typedef struct packed {
        logic signed [weight_w-1:0] weight;
        logic signed [chan_w-1:0] tap;
    } cfg_coef_t;

    typedef struct packed {
        logic signed [thresh_w-1:0] thresh;
        logic [shift_w-1:0] ffe_shift;
        logic [shift_w-1:0] chan_shift;
    } cfg_ctrl_t;

    typedef union packed {
        cfg_coef_t coef;
        cfg_ctrl_t ctrl;
    } cfg_word_u;

endpackage

`default_nettype wire

//--- hdl/ffe_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module ffe_slicer (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic signed [dsp_pkg::code_w-1:0]   codes_i [dsp_pkg::lanes-1:0],
    input  logic signed [dsp_pkg::weight_w-1:0] weights_i [dsp_pkg::ffe_taps-1:0],
    input  logic [dsp_pkg::shift_w-1:0]         shift_i,
    input  logic signed [dsp_pkg::thresh_w-1:0] thresh_i,
    output logic [dsp_pkg::lanes-1:0]           bits_o
);
    import dsp_pkg::*;

    logic signed [code_w-1:0]    prev_codes [lanes-1:0];
    logic signed [code_w-1:0]    span [ffe_span-1:0];
    logic signed [ffe_acc_w-1:0] acc [lanes-1:0];
    logic signed [ffe_acc_w-1:0] est [lanes-1:0];
    logic [lanes-1:0]            bits_d;

    // Tail of the previous word first, then the current word
    always_comb begin
        for (int i = 0; i < ffe_taps - 1; i++) begin
            span[i] = prev_codes[lanes - ffe_taps + 1 + i];
        end
        for (int s = 0; s < lanes; s++) begin
            span[ffe_taps - 1 + s] = codes_i[s];
        end
    end

    always_comb begin
        for (int s = 0; s < lanes; s++) begin
            acc[s] = '0;
            for (int k = 0; k < ffe_taps; k++) begin
                acc[s] = acc[s] + weights_i[k] * span[s + ffe_taps - 1 - k];
            end
            est[s] = acc[s] >>> shift_i;
            // Slice against sign-extended threshold
            bits_d[s] = (est[s] >= thresh_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bits_o <= '0;
            for (int s = 0; s < lanes; s++) begin
                prev_codes[s] <= '0;
            end
        end else begin
            bits_o <= bits_d;
            for (int s = 0; s < lanes; s++) begin
                prev_codes[s] <= codes_i[s];
            end
        end
    end

    bits_known_a: assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown(bits_d));

endmodule

`default_nettype wire

//--- hdl/sliding_detector.sv
`timescale 1ns/1ps
`default_nettype none

module sliding_detector (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic signed [dsp_pkg::err_w-1:0]    errors_i [dsp_pkg::lanes-1:0],
    input  logic [dsp_pkg::lanes-1:0]           bits_i,
    input  logic signed [dsp_pkg::chan_w-1:0]   taps_i [dsp_pkg::sd_taps-1:0],
    output logic [dsp_pkg::err_pos_w-1:0]       err_pos_o [dsp_pkg::lanes-1:0]
);
    import dsp_pkg::*;

    logic signed [err_w-1:0] held_err [lanes-1:0];
    logic [lanes-1:0]        held_bits;
    logic signed [err_w-1:0] win_err [lanes:0];
    logic [lanes:0]          win_bits;

    logic signed [dev_w-1:0] e_cur_f [lanes-1:0];
    logic signed [dev_w-1:0] e_nxt_f [lanes-1:0];
    logic signed [dev_w-1:0] e_nxt_p [lanes-1:0];
    logic [cost_w-1:0]       cost_none [lanes-1:0];
    logic [cost_w-1:0]       cost_single [lanes-1:0];
    logic [cost_w-1:0]       cost_pair [lanes-1:0];
    logic [cost_w-1:0]       best_cost [lanes-1:0];
    logic [err_pos_w-1:0]    best [lanes-1:0];

    function automatic logic [cost_w-1:0] sq_f(input logic signed [dev_w-1:0] v);
        logic signed [cost_w-1:0] w;
        w = v;
        return w * w;
    endfunction

    // Error change from flipping a bit is -2 * sign * tap
    function automatic logic signed [dev_w-1:0] flip_f(
        input logic b,
        input logic signed [chan_w-1:0] t
    );
        logic signed [dev_w-1:0] two_t;
        two_t = t;
        two_t = two_t <<< 1;
        return b ? -two_t : two_t;
    endfunction

    // Held word plus first sample of the next word
    always_comb begin
        for (int s = 0; s < lanes; s++) begin
            win_err[s] = held_err[s];
        end
        win_err[lanes] = errors_i[0];
    end

    assign win_bits = {bits_i[0], held_bits};

    always_comb begin
        for (int s = 0; s < lanes; s++) begin
            e_cur_f[s] = win_err[s] + flip_f(win_bits[s], taps_i[0]);
            e_nxt_f[s] = win_err[s + 1] + flip_f(win_bits[s], taps_i[1]);
            e_nxt_p[s] = e_nxt_f[s] + flip_f(win_bits[s + 1], taps_i[0]);

            cost_none[s] = sq_f(win_err[s]) + sq_f(win_err[s + 1]);
            cost_single[s] = sq_f(e_cur_f[s]) + sq_f(e_nxt_f[s]);
            cost_pair[s] = sq_f(e_cur_f[s]) + sq_f(e_nxt_p[s]);

            // Strict compare so ties keep the lower index
            best[s] = err_pos_none;
            best_cost[s] = cost_none[s];
            if (cost_single[s] < best_cost[s]) begin
                best[s] = err_pos_single;
                best_cost[s] = cost_single[s];
            end
            if (cost_pair[s] < best_cost[s]) begin
                best[s] = err_pos_pair;
                best_cost[s] = cost_pair[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            held_bits <= '0;
            for (int s = 0; s < lanes; s++) begin
                held_err[s] <= '0;
                err_pos_o[s] <= err_pos_none;
            end
        end else begin
            held_bits <= bits_i;
            for (int s = 0; s < lanes; s++) begin
                held_err[s] <= errors_i[s];
                err_pos_o[s] <= best[s];
            end
        end
    end

    for (genvar g = 0; g < lanes; g++) begin : g_chk
        errors_known_a: assert property (@(posedge clk) disable iff (rst_i)
            !$isunknown(errors_i[g]));
    end

endmodule

`default_nettype wire

//--- tests/dsp_model.svh
`ifndef DSP_MODEL_SVH
`define DSP_MODEL_SVH

// Configuration state
int m_w [3];
int m_ct [3];
int m_th;
int m_fs;
int m_cs;

// Pipeline state, one entry per stage
int       m_prev_codes [4];
bit [3:0] m_bits1;
bit [3:0] m_prev_bits;
int       m_est [4];
int       m_adc0 [4];
int       m_adc1 [4];
int       m_err [4];
int       m_held_err [4];
bit [3:0] m_held_bits;
bit [3:0] m_bdly [4];
int       m_verdict [4];

function automatic int sgn(input bit b);
    return b ? 1 : -1;
endfunction

function automatic int flip(input bit b, input int t);
    return b ? -2 * t : 2 * t;
endfunction

task automatic model_reset();
    m_w = '{1, 0, 0};
    m_ct = '{1, 0, 0};
    m_th = 0;
    m_fs = 0;
    m_cs = 0;
    m_bits1 = '0;
    m_prev_bits = '0;
    m_held_bits = '0;
    for (int i = 0; i < 4; i++) begin
        m_prev_codes[i] = 0;
        m_est[i] = 0;
        m_adc0[i] = 0;
        m_adc1[i] = 0;
        m_err[i] = 0;
        m_held_err[i] = 0;
        m_bdly[i] = '0;
        m_verdict[i] = 0;
    end
endtask

// One clock edge: every stage computed from old state, then committed
task automatic model_step(input bit rst, input int codes [4], input bit we,
                          input bit [1:0] addr, input bit [15:0] data);
    int x [6];
    bit [5:0] y;
    int we_err [5];
    bit [4:0] wb;
    bit [3:0] n_bits1;
    int n_est [4];
    int n_err [4];
    int n_verdict [4];
    int acc;
    longint c_none;
    longint c_single;
    longint c_pair;
    int ec;
    int en;
    int ep;
    if (rst) begin
        model_reset();
        return;
    end
    x[0] = m_prev_codes[2];
    x[1] = m_prev_codes[3];
    y = {m_bits1, m_prev_bits[3:2]};
    for (int s = 0; s < 4; s++) begin
        x[2 + s] = codes[s];
    end
    for (int s = 0; s < 4; s++) begin
        acc = 0;
        for (int k = 0; k < 3; k++) begin
            acc += m_w[k] * x[s + 2 - k];
        end
        n_bits1[s] = (acc >>> m_fs) >= m_th;
        acc = 0;
        for (int k = 0; k < 3; k++) begin
            acc += m_ct[k] * sgn(y[s + 2 - k]);
        end
        n_est[s] = acc >>> m_cs;
        n_err[s] = m_est[s] - m_adc1[s];
    end
    // Detector window spans the held word and sample 0 of the next
    for (int s = 0; s < 4; s++) begin
        we_err[s] = m_held_err[s];
    end
    we_err[4] = m_err[0];
    wb = {m_bdly[1][0], m_held_bits};
    for (int s = 0; s < 4; s++) begin
        ec = we_err[s] + flip(wb[s], m_ct[0]);
        en = we_err[s + 1] + flip(wb[s], m_ct[1]);
        ep = en + flip(wb[s + 1], m_ct[0]);
        c_none = we_err[s] * we_err[s] + we_err[s + 1] * we_err[s + 1];
        c_single = ec * ec + en * en;
        c_pair = ec * ec + ep * ep;
        n_verdict[s] = 0;
        if (c_single < c_none) begin
            n_verdict[s] = 1;
        end
        if (c_pair < ((n_verdict[s] == 1) ? c_single : c_none)) begin
            n_verdict[s] = 2;
        end
    end
    m_held_err = m_err;
    m_held_bits = m_bdly[1];
    m_err = n_err;
    m_bdly[3] = m_bdly[2];
    m_bdly[2] = m_bdly[1];
    m_bdly[1] = m_bdly[0];
    m_bdly[0] = m_bits1;
    m_prev_bits = m_bits1;
    m_bits1 = n_bits1;
    m_est = n_est;
    m_adc1 = m_adc0;
    m_adc0 = codes;
    m_prev_codes = codes;
    m_verdict = n_verdict;
    if (we) begin
        if (addr == 2'd3) begin
            m_th = int'($signed(data[15:8]));
            m_fs = data[7:4];
            m_cs = data[3:0];
        end else begin
            m_w[addr] = int'($signed(data[15:8]));
            m_ct[addr] = int'($signed(data[7:0]));
        end
    end
endtask

`endif

//--- tests/datapath_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_core_tb;
    import dsp_pkg::*;

    // Test lengths plus reset and margin
    localparam int cycle_limit = 10 + 8 + 100 + 300 + 200 + 300 + 200 + 100;

    logic                     clk = 1'b0;
    logic                     rst_i;
    logic signed [code_w-1:0] adc_codes_i [lanes-1:0];
    logic                     cfg_we_i;
    logic [cfg_addr_w-1:0]    cfg_addr_i;
    logic [cfg_data_w-1:0]    cfg_data_i;
    logic [lanes-1:0]         bits_o;
    logic [err_pos_w-1:0]     err_pos_o [lanes-1:0];

    bit [31:0] seed = 32'h9687e18e;
    int        err_cnt = 0;
    int        check_cnt = 0;
    int        test_cnt = 0;
    int        cycle_cnt = 0;
    int        test_err0;

    `include "dsp_model.svh"

    datapath_core dut0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .adc_codes_i(adc_codes_i),
        .cfg_we_i  (cfg_we_i),
        .cfg_addr_i(cfg_addr_i),
        .cfg_data_i(cfg_data_i),
        .bits_o    (bits_o),
        .err_pos_o (err_pos_o)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic bit [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string name, input int exp, input int act);
        check_cnt++;
        if (exp != act) begin
            err_cnt++;
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Advance one cycle and compare the DUT with the model
    task automatic tick(input string name);
        int vals [4];
        @(negedge clk);
        for (int s = 0; s < lanes; s++) begin
            vals[s] = adc_codes_i[s];
        end
        model_step(rst_i, vals, cfg_we_i, cfg_addr_i, cfg_data_i);
        check(name, m_bdly[3], bits_o);
        for (int s = 0; s < lanes; s++) begin
            check(name, m_verdict[s], err_pos_o[s]);
        end
        cfg_we_i = 1'b0;
    endtask

    task automatic drive_random_word();
        bit [31:0] r;
        r = next_rand();
        for (int s = 0; s < lanes; s++) begin
            adc_codes_i[s] = r[8*s +: 8];
        end
    endtask

    task automatic drive_cfg(input bit [1:0] addr, input bit [15:0] data);
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_data_i = data;
    endtask

    // Ideal channel 40, 12, 0 for bits b with the last bit of the previous word
    task automatic drive_channel_word(input bit [3:0] b, input bit last, input int noise);
        bit [4:0] p;
        bit [31:0] r;
        p = {b, last};
        for (int s = 0; s < lanes; s++) begin
            r = next_rand();
            adc_codes_i[s] = 40 * sgn(p[s + 1]) + 12 * sgn(p[s])
                             + (noise ? int'(r[5:0]) - 32 : 0);
        end
    endtask

    task automatic start_test();
        test_err0 = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test(input string name);
        $display("test %s done with %0d errors", name, err_cnt - test_err0);
    endtask

    task automatic test_reset();
        start_test();
        rst_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            drive_random_word();
            tick("reset");
            if (i < 4) begin
                check("reset", 0, bits_o);
                for (int s = 0; s < lanes; s++) begin
                    check("reset", err_pos_none, err_pos_o[s]);
                end
            end
        end
        end_test("reset");
    endtask

    task automatic test_default();
        bit [3:0] sq [$];
        bit [3:0] sb;
        start_test();
        for (int i = 0; i < 100; i++) begin
            drive_random_word();
            for (int s = 0; s < lanes; s++) begin
                sb[s] = !adc_codes_i[s][code_w-1];
            end
            sq.push_back(sb);
            tick("default");
            if (sq.size() > 4) begin
                check("default", sq.pop_front(), bits_o);
            end
        end
        end_test("default");
    endtask

    task automatic test_random_eq();
        bit [31:0] r;
        start_test();
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            if (i < 3) begin
                drive_cfg(i, {8'(int'(r[6:0]) - 64), 8'(int'(r[13:8]) - 32)});
            end else if (i == 3) begin
                drive_cfg(addr_ctrl, {r[7:0], 1'b0, r[10:8], 2'b00, r[13:12]});
            end
            drive_random_word();
            tick("random_eq");
        end
        end_test("random_eq");
    endtask

    task automatic test_channel(input string name, input int noise, input int len);
        bit [3:0] gq [$];
        bit [3:0] b;
        bit       last;
        int       flagged;
        start_test();
        last = 1'b0;
        flagged = 0;
        for (int i = 0; i < len; i++) begin
            if (i < 3) begin
                drive_cfg(i, (i == 0) ? {8'sd1, 8'sd40} : (i == 1) ? {8'sd0, 8'sd12} : 16'h0);
            end else if (i == 3) begin
                drive_cfg(addr_ctrl, 16'h0000);
            end
            b = next_rand();
            drive_channel_word(b, last, noise);
            last = b[3];
            gq.push_back(b);
            tick(name);
            if (gq.size() > 4) begin
                b = gq.pop_front();
                if (!noise && i >= 12) begin
                    check(name, b, bits_o);
                    for (int s = 0; s < lanes; s++) begin
                        check(name, err_pos_none, err_pos_o[s]);
                    end
                end
            end
            for (int s = 0; s < lanes; s++) begin
                flagged += (err_pos_o[s] != err_pos_none);
            end
        end
        if (noise && flagged == 0) begin
            err_cnt++;
            $display("error: test %s saw no single or pair verdicts", name);
        end
        end_test(name);
    endtask

    task automatic test_reconfig();
        bit [31:0] r;
        start_test();
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            if (r[31:28] == 4'd0 || i == 100) begin
                drive_cfg(r[1:0], r[27:12]);
            end
            drive_random_word();
            tick("reconfig");
        end
        end_test("reconfig");
    endtask

    initial begin
        rst_i = 1'b1;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_data_i = '0;
        for (int s = 0; s < lanes; s++) begin
            adc_codes_i[s] = '0;
        end
        model_reset();
        for (int i = 0; i < 10; i++) begin
            tick("in_reset");
        end
        test_reset();
        test_default();
        test_random_eq();
        test_channel("clean_channel", 0, 200);
        test_channel("noisy_channel", 1, 300);
        test_reconfig();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
